//--- hdl/mult_pkg.sv
package mult_pkg;

    // operand and product sizes.
    localparam int OPERAND_WIDTH = 8;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // counter runs 0 .. OPERAND_WIDTH, so it needs one bit more than log2.
    localparam int COUNT_WIDTH = 4;

    // sequencer states.
    typedef enum logic [1:0]
    {
        IDLE, // waiting for operands.
        CALC, // iterating.
        WAIT  // result held until taken.
    } ctrl_state_t;

endpackage

//--- hdl/mult_control.sv
`timescale 1ns/100ps

module mult_control (
    input  logic clk,
    input  logic rst,

    input  logic done,
    input  logic src_valid,
    input  logic dd_ready,
    input  logic temp,

    output logic selc_A,
    output logic enable_count,
    output logic enable_registers,
    output logic src_ready,
    output logic dd_valid
);

    import mult_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    // outputs decoded from the registered state and the inputs.
    always_comb
    begin
        case (state)
            IDLE:
            begin
                src_ready    = 1'b1;
                dd_valid     = 1'b0;
                enable_count = 1'b0;
                selc_A       = 1'b0;
                if (src_valid)
                begin
                    enable_registers = 1'b1; // operands taken at this edge.
                    next_state       = CALC;
                end
                else
                begin
                    enable_registers = 1'b0;
                    next_state       = IDLE;
                end
            end

            CALC:
            begin
                src_ready        = 1'b0;
                dd_valid         = 1'b0;
                enable_registers = 1'b0;
                if (done)
                begin
                    enable_count = 1'b0;
                    selc_A       = 1'b0;
                    next_state   = WAIT;
                end
                else
                begin
                    enable_count = 1'b1;
                    selc_A       = temp; // add only on a set multiplier bit.
                    next_state   = CALC;
                end
            end

            WAIT:
            begin
                src_ready        = 1'b0;
                dd_valid         = 1'b1;
                enable_registers = 1'b0;
                enable_count     = 1'b0;
                selc_A           = 1'b0;
                if (dd_ready)
                begin
                    next_state = IDLE; // result taken.
                end
                else
                begin
                    next_state = WAIT;
                end
            end

            default:
            begin
                src_ready        = 1'b0;
                dd_valid         = 1'b0;
                enable_registers = 1'b0;
                enable_count     = 1'b0;
                selc_A           = 1'b0;
                next_state       = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    // one multiplication in flight: no new operands while a result is offered.
    a_no_accept_while_pending : assert property (
        @(posedge clk) disable iff (rst)
        !(dd_valid && src_ready)
    )
    else
        $error("src_ready and dd_valid high together");

endmodule

//--- hdl/shift_add_datapath.sv
`timescale 1ns/100ps

module shift_add_datapath (
    input  logic                               clk,
    input  logic                               rst,

    input  logic [mult_pkg::OPERAND_WIDTH-1:0] a,
    input  logic [mult_pkg::OPERAND_WIDTH-1:0] b,

    input  logic                               enable_registers,
    input  logic                               enable_count,
    input  logic                               selc_A,

    output logic                               temp,
    output logic                               done,
    output logic [mult_pkg::PRODUCT_WIDTH-1:0] product
);

    import mult_pkg::*;

    logic [PRODUCT_WIDTH-1:0] multiplicand_reg;
    logic [OPERAND_WIDTH-1:0] multiplier_reg;
    logic [PRODUCT_WIDTH-1:0] accumulator;
    logic [PRODUCT_WIDTH-1:0] add_term;
    logic [COUNT_WIDTH-1:0]   count;

    // multiplicand, widened to product size and shifted left each step.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            multiplicand_reg <= '0;
        end
        else if (enable_registers)
        begin
            multiplicand_reg <= {{(PRODUCT_WIDTH - OPERAND_WIDTH){1'b0}}, a};
        end
        else if (enable_count)
        begin
            multiplicand_reg <= {multiplicand_reg[PRODUCT_WIDTH-2:0], 1'b0};
        end
    end

    // multiplier, shifted right so bit 0 is always the current bit.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            multiplier_reg <= '0;
        end
        else if (enable_registers)
        begin
            multiplier_reg <= b;
        end
        else if (enable_count)
        begin
            multiplier_reg <= {1'b0, multiplier_reg[OPERAND_WIDTH-1:1]};
        end
    end

    assign add_term = selc_A ? multiplicand_reg : '0;

    // partial product sum.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            accumulator <= '0;
        end
        else if (enable_registers)
        begin
            accumulator <= '0; // fresh sum for new operands.
        end
        else if (enable_count)
        begin
            accumulator <= accumulator + add_term;
        end
    end

    // iteration counter.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            count <= '0;
        end
        else if (enable_registers)
        begin
            count <= '0;
        end
        else if (enable_count)
        begin
            count <= count + 1'b1;
        end
    end

    assign temp    = multiplier_reg[0];
    assign done    = (count == COUNT_WIDTH'(OPERAND_WIDTH));
    assign product = accumulator;

    // the sequencer must stop stepping once done is reported.
    a_count_bounded : assert property (
        @(posedge clk) disable iff (rst)
        count <= COUNT_WIDTH'(OPERAND_WIDTH)
    )
    else
        $error("iteration counter ran past OPERAND_WIDTH: %0d", count);

endmodule

//--- hdl/mult_top.sv
`timescale 1ns/100ps

module mult_top (
    input  logic                               clk,
    input  logic                               rst,

    // source side.
    input  logic                               src_valid,
    input  logic [mult_pkg::OPERAND_WIDTH-1:0] a,
    input  logic [mult_pkg::OPERAND_WIDTH-1:0] b,
    output logic                               src_ready,

    // destination side.
    input  logic                               dd_ready,
    output logic                               dd_valid,
    output logic [mult_pkg::PRODUCT_WIDTH-1:0] product
);

    // sequencer to datapath.
    logic enable_registers;
    logic enable_count;
    logic selc_A;

    // datapath to sequencer.
    logic temp;
    logic done;

    mult_control i_control (
        .clk              (clk),
        .rst              (rst),
        .done             (done),
        .src_valid        (src_valid),
        .dd_ready         (dd_ready),
        .temp             (temp),
        .selc_A           (selc_A),
        .enable_count     (enable_count),
        .enable_registers (enable_registers),
        .src_ready        (src_ready),
        .dd_valid         (dd_valid)
    );

    shift_add_datapath i_datapath (
        .clk              (clk),
        .rst              (rst),
        .a                (a),
        .b                (b),
        .enable_registers (enable_registers),
        .enable_count     (enable_count),
        .selc_A           (selc_A),
        .temp             (temp),
        .done             (done),
        .product          (product)
    );

endmodule

//--- verification/mult_checker.sv
`timescale 1ns/100ps

module mult_checker #(
    parameter int NAME_BITS = 128
) (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               src_valid,
    input  logic                               src_ready,
    input  logic [mult_pkg::OPERAND_WIDTH-1:0] a,
    input  logic [mult_pkg::OPERAND_WIDTH-1:0] b,

    input  logic                               dd_valid,
    input  logic                               dd_ready,
    input  logic [mult_pkg::PRODUCT_WIDTH-1:0] product,

    input  logic [NAME_BITS-1:0]               test_name,
    input  logic [mult_pkg::PRODUCT_WIDTH-1:0] expected_product,
    input  logic                               end_of_run,

    output int                                 error_count,
    output int                                 products_checked
);

    import mult_pkg::*;

    // one entry per accepted operand pair, oldest first.
    logic [OPERAND_WIDTH-1:0] a_queue[$];
    logic [OPERAND_WIDTH-1:0] b_queue[$];
    logic [PRODUCT_WIDTH-1:0] table_queue[$];
    logic [NAME_BITS-1:0]     name_queue[$];

    logic [PRODUCT_WIDTH-1:0] held_product;
    logic                     hold_pending; // result offered but not taken last edge.
    logic                     busy;         // between acceptance and transfer.
    logic                     valid_seen;
    logic                     after_reset;
    logic                     end_checked;
    int                       low_edges;

    always @(posedge clk)
    begin : watch
        logic [OPERAND_WIDTH-1:0] op_a;
        logic [OPERAND_WIDTH-1:0] op_b;
        logic [PRODUCT_WIDTH-1:0] want;
        logic [PRODUCT_WIDTH-1:0] listed;
        logic [NAME_BITS-1:0]     name;
        if (rst)
        begin
            a_queue.delete();
            b_queue.delete();
            table_queue.delete();
            name_queue.delete();
            held_product     = '0;
            hold_pending     = 1'b0;
            busy             = 1'b0;
            valid_seen       = 1'b0;
            after_reset      = 1'b1;
            end_checked      = 1'b0;
            low_edges        = 0;
            error_count      = 0;
            products_checked = 0;
        end
        else
        begin
            name = (name_queue.size() > 0) ? name_queue[0] : '0;

            if (after_reset)
            begin
                after_reset = 1'b0;
                if (!src_ready || dd_valid)
                begin
                    $display("ERROR: after reset src_ready=%b dd_valid=%b, expected 1 and 0",
                             src_ready, dd_valid);
                    error_count++;
                end
            end

            if (src_ready && dd_valid)
            begin
                $display("ERROR: src_ready and dd_valid are high together");
                error_count++;
            end
            if (busy && src_ready)
            begin
                $display("ERROR: %0s: src_ready is high while a result is pending", name);
                error_count++;
            end

            // back-pressure must freeze the offered result.
            if (hold_pending)
            begin
                if (!dd_valid)
                begin
                    $display("ERROR: %0s: dd_valid dropped before the result was taken", name);
                    error_count++;
                end
                else if (product !== held_product)
                begin
                    $display("CHECK FAILED test=%0s expected=%h actual=%h", name,
                             held_product, product);
                    error_count++;
                end
            end

            if (busy && !valid_seen)
            begin
                if (dd_valid)
                begin
                    valid_seen = 1'b1;
                    if (low_edges != OPERAND_WIDTH + 1)
                    begin
                        $display("ERROR: %0s: dd_valid rose at edge %0d after acceptance, not %0d",
                                 name, low_edges, OPERAND_WIDTH + 1);
                        error_count++;
                    end
                end
                else
                begin
                    low_edges++;
                end
            end

            if (dd_valid && dd_ready)
            begin
                if (a_queue.size() == 0)
                begin
                    $display("ERROR: a result was taken with no accepted operands behind it");
                    error_count++;
                end
                else
                begin
                    op_a   = a_queue.pop_front();
                    op_b   = b_queue.pop_front();
                    listed = table_queue.pop_front();
                    name   = name_queue.pop_front();
                    want   = PRODUCT_WIDTH'(op_a) * PRODUCT_WIDTH'(op_b);
                    if (product !== want)
                    begin
                        $display("CHECK FAILED test=%0s expected=%h actual=%h", name, want,
                                 product);
                        error_count++;
                    end
                    if (listed !== want)
                    begin
                        $display("ERROR: %0s: stimulus lists %h, but %0d x %0d is %h", name,
                                 listed, op_a, op_b, want);
                        error_count++;
                    end
                    products_checked++;
                end
                busy = 1'b0;
            end

            if (src_valid && src_ready)
            begin
                a_queue.push_back(a);
                b_queue.push_back(b);
                table_queue.push_back(expected_product);
                name_queue.push_back(test_name);
                busy       = 1'b1;
                valid_seen = 1'b0;
                low_edges  = 0;
            end

            hold_pending = dd_valid && !dd_ready;
            held_product = product;

            if (end_of_run && !end_checked)
            begin
                end_checked = 1'b1;
                if (a_queue.size() != 0)
                begin
                    $display("ERROR: %0d accepted operand pairs never produced a result",
                             a_queue.size());
                    error_count++;
                end
            end
        end
    end

endmodule

//--- verification/mult_tb.sv
`timescale 1ns/100ps

module mult_tb;

    import mult_pkg::*;

    localparam int          CLK_HALF     = 20;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          RESET_CYCLES = 10;
    localparam int          WAIT_LIMIT   = 50;
    localparam int          TABLE_LEN    = 8;
    localparam int          RANDOM_PAIRS = 40;
    localparam int          NAME_CHARS   = 16;
    localparam logic [31:0] LCG_SEED     = 32'h0116_1e56;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     src_valid;
    logic [OPERAND_WIDTH-1:0] a;
    logic [OPERAND_WIDTH-1:0] b;
    logic                     src_ready;
    logic                     dd_ready;
    logic                     dd_valid;
    logic [PRODUCT_WIDTH-1:0] product;

    logic [8*NAME_CHARS-1:0]  test_name;
    logic [PRODUCT_WIDTH-1:0] expected_product;
    logic                     end_of_run;
    int                       check_errors;
    int                       products_checked;
    int                       timeout_errors;

    // stimulus table.
    string                    name_table[TABLE_LEN];
    logic [OPERAND_WIDTH-1:0] a_table[TABLE_LEN];
    logic [OPERAND_WIDTH-1:0] b_table[TABLE_LEN];
    int                       stall_table[TABLE_LEN];
    logic [PRODUCT_WIDTH-1:0] product_table[TABLE_LEN];

    always #(CLK_HALF) clk = ~clk;

    mult_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .src_valid (src_valid),
        .a         (a),
        .b         (b),
        .src_ready (src_ready),
        .dd_ready  (dd_ready),
        .dd_valid  (dd_valid),
        .product   (product)
    );

    mult_checker #(
        .NAME_BITS (8 * NAME_CHARS)
    ) i_checker (
        .clk              (clk),
        .rst              (rst),
        .src_valid        (src_valid),
        .src_ready        (src_ready),
        .a                (a),
        .b                (b),
        .dd_valid         (dd_valid),
        .dd_ready         (dd_ready),
        .product          (product),
        .test_name        (test_name),
        .expected_product (expected_product),
        .end_of_run       (end_of_run),
        .error_count      (check_errors),
        .products_checked (products_checked)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] value);
        return value * 32'd1664525 + 32'd1013904223;
    endfunction

    // right-aligned ascii, so the checker can print it with %s.
    function automatic logic [8*NAME_CHARS-1:0] pack_name(input string s);
        logic [8*NAME_CHARS-1:0] packed_name;
        packed_name = '0;
        for (int i = 0; i < s.len() && i < NAME_CHARS; i++)
        begin
            packed_name = {packed_name[8*NAME_CHARS-9:0], s[i]};
        end
        return packed_name;
    endfunction

    task automatic set_entry(input int idx, input string name, input logic [7:0] a_val,
                             input logic [7:0] b_val, input int stall,
                             input logic [15:0] want);
        name_table[idx]    = name;
        a_table[idx]       = a_val;
        b_table[idx]       = b_val;
        stall_table[idx]   = stall;
        product_table[idx] = want;
    endtask

    // one full multiplication: offer, wait for the result, stall, take it.
    task automatic run_transfer(input string name, input logic [OPERAND_WIDTH-1:0] a_val,
                                input logic [OPERAND_WIDTH-1:0] b_val, input int stall,
                                input logic [PRODUCT_WIDTH-1:0] want);
        int   cycles;
        logic accepted;
        logic offered;
        logic taken;
        test_name        = pack_name(name);
        a                = a_val;
        b                = b_val;
        expected_product = want;
        src_valid        = 1'b1;
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            accepted = src_ready; // src_valid is high, so this edge takes them.
            cycles++;
        end
        #DRIVE_DELAY;
        src_valid = 1'b0;
        if (!accepted)
        begin
            $display("ERROR: %s: operands not accepted within %0d cycles", name, WAIT_LIMIT);
            timeout_errors++;
            return;
        end
        cycles  = 0;
        offered = 1'b0;
        while (!offered && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            offered = dd_valid;
            cycles++;
        end
        if (!offered)
        begin
            $display("ERROR: %s: no result offered within %0d cycles", name, WAIT_LIMIT);
            timeout_errors++;
            return;
        end
        repeat (stall) @(posedge clk);
        #DRIVE_DELAY;
        dd_ready = 1'b1;
        cycles = 0;
        taken  = 1'b0;
        while (!taken && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            taken = dd_valid;
            cycles++;
        end
        #DRIVE_DELAY;
        dd_ready = 1'b0;
        if (!taken)
        begin
            $display("ERROR: %s: result not taken within %0d cycles", name, WAIT_LIMIT);
            timeout_errors++;
        end
    endtask

    initial
    begin : stimulus
        logic [31:0]              lcg_state;
        logic [OPERAND_WIDTH-1:0] rand_a;
        logic [OPERAND_WIDTH-1:0] rand_b;
        int                       rand_stall;
        rst              = 1'b1;
        src_valid        = 1'b0;
        a                = '0;
        b                = '0;
        dd_ready         = 1'b0;
        test_name        = '0;
        expected_product = '0;
        end_of_run       = 1'b0;
        timeout_errors   = 0;
        lcg_state        = LCG_SEED;

        set_entry(0, "zero_by_zero", 8'd0, 8'd0, 0, 16'd0);
        set_entry(1, "one_by_max", 8'd1, 8'd255, 2, 16'd255);
        set_entry(2, "max_by_max", 8'd255, 8'd255, 5, 16'd65025);
        set_entry(3, "msb_by_two", 8'd128, 8'd2, 0, 16'd256);
        set_entry(4, "alternating", 8'd170, 8'd85, 3, 16'd14450);
        set_entry(5, "max_by_one", 8'd255, 8'd1, 1, 16'd255);
        set_entry(6, "two_by_three", 8'd2, 8'd3, 0, 16'd6);
        set_entry(7, "odd_pair", 8'd13, 8'd11, 7, 16'd143);

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        for (int i = 0; i < TABLE_LEN; i++)
        begin
            run_transfer(name_table[i], a_table[i], b_table[i], stall_table[i],
                         product_table[i]);
        end

        for (int i = 0; i < RANDOM_PAIRS; i++)
        begin
            lcg_state  = lcg_next(lcg_state);
            rand_a     = lcg_state[31:24];
            rand_b     = lcg_state[23:16];
            rand_stall = int'(lcg_state[10:8]); // 0 to 7 stall cycles.
            run_transfer("random_pair", rand_a, rand_b, rand_stall,
                         PRODUCT_WIDTH'(rand_a) * PRODUCT_WIDTH'(rand_b));
        end

        end_of_run = 1'b1;
        repeat (2) @(posedge clk);
        $display("check errors: %0d, timeout errors: %0d, results checked: %0d",
                 check_errors, timeout_errors, products_checked);
        if (check_errors == 0 && timeout_errors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/mult_pkg.sv
hdl/mult_control.sv
hdl/shift_add_datapath.sv
hdl/mult_top.sv
verification/mult_checker.sv
verification/mult_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mult_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "FAIL: run ended early, see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
